/* logic/metis_consts.svh */
`ifndef METIS_CONSTS_SVH
`define METIS_CONSTS_SVH

// ----------------------------------------------------------------------
// Fixed frame bytes
// ----------------------------------------------------------------------
`define METIS_TYPE_1       8'hEF   // First byte of every frame
`define METIS_TYPE_2       8'hFE   // Second byte of every frame
`define METIS_HPSDR_FRAME  8'h01   // Streaming frame marker
`define METIS_EP_IQ        8'h06   // Receiver I/Q endpoint
`define METIS_EP_WIDE      8'h04   // Wide spectrum endpoint

// ----------------------------------------------------------------------
// Lengths and thresholds
// ----------------------------------------------------------------------
`define METIS_DATA_LEN     1032    // Streaming frame bytes
`define METIS_DISC_LEN     60      // Discovery reply bytes
`define METIS_IQ_THRESHOLD 1023    // I/Q start needs level above this
`define METIS_HDR_LEN      8       // First payload byte index
`define METIS_LEN_W        11      // Length and index width

`endif

/* logic/metis_pkg.sv */
`default_nettype none

`include "metis_consts.svh"

package metis_pkg;

	// ------------------------------------------------------------------
	// Frame kinds
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		NONE, // No frame in flight
		IQ,   // Receiver I/Q samples
		WIDE, // Wide spectrum samples
		DISC  // Discovery reply
	} frame_kind_e;

	// Station identity for discovery replies
	typedef struct packed {
		logic [47:0] mac;         // Board MAC address
		logic [7:0]  serial_no;   // Firmware serial number
		logic        hermes_lite; // Report as Hermes-Lite
		logic [7:0]  assign_nr;   // Assigned receiver number
	} station_id_s;

	// Request towards the UDP sender
	typedef struct packed {
		logic                    request; // Frame pending
		logic [`METIS_LEN_W-1:0] length;  // UDP payload bytes
	} udp_req_s;

	// Show-ahead FIFO read side
	typedef struct packed {
		logic [7:0]              data; // Head byte
		logic [`METIS_LEN_W-1:0] used; // Fill level
	} fifo_rd_s;

	// Kind and index of the byte loaded next
	typedef struct packed {
		frame_kind_e             kind;
		logic [`METIS_LEN_W-1:0] index;
	} byte_pos_s;

endpackage

`default_nettype wire

/* logic/tx_frame_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "metis_consts.svh"

module tx_frame_ctrl (
	input  wire logic                    tx_clock,
	input  wire logic                    rst,
	input  wire logic                    run,
	input  wire logic                    wide_spectrum,
	input  wire logic                    ip_valid,
	input  wire logic                    discovery,
	input  wire logic                    tx_reset,
	input  wire logic [`METIS_LEN_W-1:0] iq_used,
	input  wire logic                    have_sp_data,
	input  wire logic                    udp_tx_enable,
	input  wire logic                    udp_tx_active,
	input  wire logic [7:0]              hdr_byte,
	input  wire logic [7:0]              pay_byte,
	input  wire logic [7:0]              disc_byte,
	output metis_pkg::udp_req_s          udp_req,
	output logic [7:0]                   udp_tx_data,
	output metis_pkg::byte_pos_s         pos,
	output logic                         advance,
	output logic                         frame_done
);

	localparam logic [`METIS_LEN_W-1:0] DATA_LEN     = `METIS_DATA_LEN;
	localparam logic [`METIS_LEN_W-1:0] DISC_LEN     = `METIS_DISC_LEN;
	localparam logic [`METIS_LEN_W-1:0] HDR_LEN      = `METIS_HDR_LEN;
	localparam logic [`METIS_LEN_W-1:0] IQ_THRESHOLD = `METIS_IQ_THRESHOLD;

	typedef enum logic [1:0] {IDLE, REQUEST, SEND, DONE} state_e;
	typedef enum logic [1:0] {SEL_HDR, SEL_PAY, SEL_DISC} sel_e;

	state_e                  state;
	metis_pkg::frame_kind_e  kind;      // Kind of frame in flight
	logic [`METIS_LEN_W-1:0] index;     // Index of next byte to load
	metis_pkg::frame_kind_e  due_kind;  // Arbitration winner
	logic [`METIS_LEN_W-1:0] due_len;
	sel_e                    byte_sel;
	logic [7:0]              next_byte;

	// ------------------------------------------------------------------
	// Arbitration, discovery first then I/Q then spectrum
	// ------------------------------------------------------------------
	always_comb begin
		due_kind = metis_pkg::NONE;
		due_len  = '0;
		if (discovery && ip_valid) begin // Reply only with a valid IP
			due_kind = metis_pkg::DISC;
			due_len  = DISC_LEN;
		end else if (iq_used > IQ_THRESHOLD && !tx_reset && run) begin
			due_kind = metis_pkg::IQ; // Full payload waiting
			due_len  = DATA_LEN;
		end else if (have_sp_data && wide_spectrum) begin
			due_kind = metis_pkg::WIDE;
			due_len  = DATA_LEN;
		end
	end

	// Which datapath block owns the next byte
	always_comb begin
		if (kind == metis_pkg::DISC)
			byte_sel = SEL_DISC;
		else if (index < HDR_LEN)
			byte_sel = SEL_HDR; // Header bytes 1 to 7
		else
			byte_sel = SEL_PAY;
	end

	always_comb begin
		case (byte_sel)
			SEL_DISC: next_byte = disc_byte;
			SEL_PAY:  next_byte = pay_byte;
			default:  next_byte = hdr_byte;
		endcase
	end

	assign pos        = '{kind: kind, index: index};
	assign advance    = (state == SEND) && udp_tx_active; // Byte loads this edge
	assign frame_done = (state == DONE);

	// ------------------------------------------------------------------
	// Handshake and byte counter
	// ------------------------------------------------------------------
	always_ff @(posedge tx_clock) begin
		if (rst) begin
			state       <= IDLE;
			kind        <= metis_pkg::NONE;
			index       <= '0;
			udp_req     <= '0;
			udp_tx_data <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (due_kind != metis_pkg::NONE) begin
						udp_req.request <= 1'b1;
						udp_req.length  <= due_len;
						kind            <= due_kind;
						index           <= '0;
						state           <= REQUEST;
					end
				end
				REQUEST: begin
					if (udp_tx_enable) begin // Sender granted
						udp_tx_data <= `METIS_TYPE_1;
						index       <= `METIS_LEN_W'(1);
						state       <= SEND;
					end
				end
				SEND: begin
					if (udp_tx_active) begin // Low holds the byte
						udp_tx_data <= next_byte;
						if (index == udp_req.length - 1'b1) begin
							udp_req <= '0; // Last byte loaded
							state   <= DONE;
						end else begin
							index <= index + 1'b1;
						end
					end
				end
				default: begin // DONE strobe
					kind  <= metis_pkg::NONE;
					index <= '0;
					state <= IDLE;
				end
			endcase
		end
	end

	// Index stays inside the granted length
	a_index_in_len: assert property (@(posedge tx_clock) disable iff (rst)
		(state == SEND) |-> (index < udp_req.length));

	// Request only drops at the end of a frame
	a_req_fall: assert property (@(posedge tx_clock) disable iff (rst)
		$fell(udp_req.request) |-> frame_done);

endmodule

`default_nettype wire

/* logic/frame_header_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "metis_consts.svh"

module frame_header_gen (
	input  wire logic            tx_clock,
	input  wire logic            rst,
	input  wire logic            run,
	input  metis_pkg::byte_pos_s pos,
	input  wire logic            frame_done,
	output logic [7:0]           hdr_byte
);

	logic [31:0] seq_iq;   // I/Q frame sequence
	logic [31:0] seq_wide; // Spectrum frame sequence
	logic [31:0] seq;      // Counter of current kind
	logic [7:0]  endpoint;

	// ------------------------------------------------------------------
	// Sequence counters
	// ------------------------------------------------------------------
	always_ff @(posedge tx_clock) begin
		if (rst || !run) begin // Both restart while stopped
			seq_iq   <= '0;
			seq_wide <= '0;
		end else if (frame_done) begin
			case (pos.kind)
				metis_pkg::IQ:   seq_iq   <= seq_iq + 32'd1;
				metis_pkg::WIDE: seq_wide <= seq_wide + 32'd1;
				default: ; // Discovery has no sequence
			endcase
		end
	end

	assign seq      = (pos.kind == metis_pkg::WIDE) ? seq_wide : seq_iq;
	assign endpoint = (pos.kind == metis_pkg::WIDE) ? `METIS_EP_WIDE : `METIS_EP_IQ;

	// Header bytes, sequence MSB first
	always_comb begin
		case (pos.index)
			11'd1:   hdr_byte = `METIS_TYPE_2;
			11'd2:   hdr_byte = `METIS_HPSDR_FRAME;
			11'd3:   hdr_byte = endpoint;
			11'd4:   hdr_byte = seq[31:24];
			11'd5:   hdr_byte = seq[23:16];
			11'd6:   hdr_byte = seq[15:8];
			11'd7:   hdr_byte = seq[7:0];
			default: hdr_byte = `METIS_TYPE_1; // Byte 0 is loaded by the FSM
		endcase
	end

	// Control must tag every finished frame
	a_done_kind: assert property (@(posedge tx_clock) disable iff (rst)
		frame_done |-> (pos.kind != metis_pkg::NONE));

endmodule

`default_nettype wire

/* logic/payload_reader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "metis_consts.svh"

module payload_reader (
	input  wire logic            tx_clock,
	input  wire logic            rst,
	input  metis_pkg::byte_pos_s pos,
	input  wire logic            advance,
	input  metis_pkg::fifo_rd_s  iq_fifo,
	input  metis_pkg::fifo_rd_s  sp_fifo,
	output logic [7:0]           pay_byte,
	output logic                 iq_fifo_rdreq,
	output logic                 sp_fifo_rdreq,
	output logic                 underrun
);

	localparam logic [`METIS_LEN_W-1:0] DATA_LEN = `METIS_DATA_LEN;
	localparam logic [`METIS_LEN_W-1:0] HDR_LEN  = `METIS_HDR_LEN;
	localparam logic [`METIS_LEN_W-1:0] LAST_IDX = DATA_LEN - 1'b1;
	localparam logic [`METIS_LEN_W-1:0] PAY_LEN  = DATA_LEN - HDR_LEN;

	logic                    streaming; // I/Q or spectrum frame
	logic                    pop;
	logic [`METIS_LEN_W-1:0] pop_cnt;   // Pops in current frame

	assign streaming = (pos.kind == metis_pkg::IQ) || (pos.kind == metis_pkg::WIDE);
	assign pop       = advance && streaming && (pos.index >= HDR_LEN);

	// Show-ahead heads, popped as they are loaded
	assign pay_byte      = (pos.kind == metis_pkg::WIDE) ? sp_fifo.data : iq_fifo.data;
	assign iq_fifo_rdreq = pop && (pos.kind == metis_pkg::IQ);
	assign sp_fifo_rdreq = pop && (pos.kind == metis_pkg::WIDE);

	// ------------------------------------------------------------------
	// Pop counter and underrun flag
	// ------------------------------------------------------------------
	always_ff @(posedge tx_clock) begin
		if (rst || pos.index == '0) // Index 0 between frames
			pop_cnt <= '0;
		else if (pop)
			pop_cnt <= pop_cnt + 1'b1;
	end

	always_ff @(posedge tx_clock) begin
		if (rst) begin
			underrun <= 1'b0;
		end else if ((iq_fifo_rdreq && iq_fifo.used == '0) ||
		             (sp_fifo_rdreq && sp_fifo.used == '0)) begin
			underrun <= 1'b1; // Sticky
		end
	end

	a_one_rdreq: assert property (@(posedge tx_clock) disable iff (rst)
		!(iq_fifo_rdreq && sp_fifo_rdreq));

	// Whole payload drained by the last byte
	a_pop_count: assert property (@(posedge tx_clock) disable iff (rst)
		(pop && pos.index == LAST_IDX) |=> (pop_cnt == PAY_LEN));

endmodule

`default_nettype wire

/* logic/discovery_reply_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "metis_consts.svh"

module discovery_reply_gen (
	input  wire logic              run,
	input  metis_pkg::station_id_s station,
	input  metis_pkg::byte_pos_s   pos,
	output logic [7:0]             disc_byte
);

	logic [7:0] emu_id; // Board ID, also the fill byte

	assign emu_id = station.hermes_lite ? 8'h06 : 8'h01;

	// ------------------------------------------------------------------
	// Reply layout
	// ------------------------------------------------------------------
	always_comb begin
		case (pos.index)
			11'd0:   disc_byte = `METIS_TYPE_1;
			11'd1:   disc_byte = `METIS_TYPE_2;
			11'd2:   disc_byte = run ? 8'h03 : 8'h02; // Busy when running
			// MAC, most significant byte first
			11'd3:   disc_byte = station.mac[47:40];
			11'd4:   disc_byte = station.mac[39:32];
			11'd5:   disc_byte = station.mac[31:24];
			11'd6:   disc_byte = station.mac[23:16];
			11'd7:   disc_byte = station.mac[15:8];
			11'd8:   disc_byte = station.mac[7:0];
			11'd9:   disc_byte = station.serial_no;
			11'd10:  disc_byte = emu_id;
			// Emulation name for skimmer clients
			11'd11:  disc_byte = "H";
			11'd12:  disc_byte = "E";
			11'd13:  disc_byte = "R";
			11'd14:  disc_byte = "M";
			11'd15:  disc_byte = "E";
			11'd16:  disc_byte = "S";
			11'd17:  disc_byte = "L";
			11'd18:  disc_byte = "T";
			11'd19:  disc_byte = station.assign_nr; // Receiver number
			default: disc_byte = emu_id;            // Bytes 20 to 59
		endcase
	end

endmodule

`default_nettype wire

/* logic/tx_send.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_send (
	input  wire logic              tx_clock,
	input  wire logic              rst,
	input  wire logic              run,
	input  wire logic              wide_spectrum,
	input  wire logic              ip_valid,
	input  wire logic              discovery,
	input  wire logic              tx_reset,      // Blocks I/Q frames
	input  metis_pkg::station_id_s station,
	input  metis_pkg::fifo_rd_s    iq_fifo,
	output logic                   iq_fifo_rdreq,
	input  metis_pkg::fifo_rd_s    sp_fifo,
	input  wire logic              have_sp_data,
	output logic                   sp_fifo_rdreq,
	output metis_pkg::udp_req_s    udp_req,       // To UDP sender
	output logic [7:0]             udp_tx_data,
	input  wire logic              udp_tx_enable,
	input  wire logic              udp_tx_active,
	output logic                   underrun
);

	metis_pkg::byte_pos_s pos;
	logic                 advance;
	logic                 frame_done;
	logic [7:0]           hdr_byte;
	logic [7:0]           pay_byte;
	logic [7:0]           disc_byte;

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------
	tx_frame_ctrl ctrl_i (
		.tx_clock      (tx_clock),
		.rst           (rst),
		.run           (run),
		.wide_spectrum (wide_spectrum),
		.ip_valid      (ip_valid),
		.discovery     (discovery),
		.tx_reset      (tx_reset),
		.iq_used       (iq_fifo.used),
		.have_sp_data  (have_sp_data),
		.udp_tx_enable (udp_tx_enable),
		.udp_tx_active (udp_tx_active),
		.hdr_byte      (hdr_byte),
		.pay_byte      (pay_byte),
		.disc_byte     (disc_byte),
		.udp_req       (udp_req),
		.udp_tx_data   (udp_tx_data),
		.pos           (pos),
		.advance       (advance),
		.frame_done    (frame_done)
	);

	// ------------------------------------------------------------------
	// Datapath
	// ------------------------------------------------------------------
	frame_header_gen hdr_i (
		.tx_clock   (tx_clock),
		.rst        (rst),
		.run        (run),
		.pos        (pos),
		.frame_done (frame_done),
		.hdr_byte   (hdr_byte)
	);

	payload_reader pay_i (
		.tx_clock      (tx_clock),
		.rst           (rst),
		.pos           (pos),
		.advance       (advance),
		.iq_fifo       (iq_fifo),
		.sp_fifo       (sp_fifo),
		.pay_byte      (pay_byte),
		.iq_fifo_rdreq (iq_fifo_rdreq),
		.sp_fifo_rdreq (sp_fifo_rdreq),
		.underrun      (underrun)
	);

	discovery_reply_gen disc_i ( // Pure lookup
		.run       (run),
		.station   (station),
		.pos       (pos),
		.disc_byte (disc_byte)
	);

endmodule

`default_nettype wire

/* tb/tb_tx_send_tasks.svh */
`ifndef TB_TX_SEND_TASKS_SVH
`define TB_TX_SEND_TASKS_SVH

	// ------------------------------------------------------------------
	// Typed compare tasks
	// ------------------------------------------------------------------
	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("error %s: expected %02h, got %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_req(input string name, input metis_pkg::udp_req_s exp,
	                         input metis_pkg::udp_req_s act);
		if (act !== exp) begin
			$display("error %s: expected req %0b len %0d, got req %0b len %0d",
			         name, exp.request, exp.length, act.request, act.length);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s: expected %0b, got %0b", name, exp, act);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------
	// Sender model and frame receiver
	// ------------------------------------------------------------------
	task automatic wait_request();
		while (!udp_req.request)
			@(negedge tx_clock);
	endtask

	task automatic expect_no_request(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge tx_clock);
			check_flag(name, 1'b0, udp_req.request);
		end
	endtask

	// Grants after 1 to 4 cycles, then clocks in one byte per active cycle
	task automatic receive_frame(input string name, input logic [10:0] len);
		metis_pkg::udp_req_s exp_req;
		int                  count;
		wait_request();
		exp_req.request = 1'b1;
		exp_req.length  = len;
		check_req({name, " request"}, exp_req, udp_req);
		repeat (1 + ($random(seed) & 3)) @(negedge tx_clock);
		udp_tx_enable = 1'b1;
		@(negedge tx_clock);
		udp_tx_enable = 1'b0;
		rx_bytes[0]   = udp_tx_data; // Loaded on the grant edge
		count         = 1;
		while (count < len) begin
			udp_tx_active = !backpressure || (($random(seed) & 3) != 0);
			@(negedge tx_clock);
			if (udp_tx_active) begin
				rx_bytes[count] = udp_tx_data;
				count++;
			end
		end
		udp_tx_active = 1'b0;
		check_req({name, " end"}, '0, udp_req); // Drops with the last byte
	endtask

	task automatic compare_frame(input string name, input int len);
		int i;
		for (i = 0; i < len; i++)
			check_byte($sformatf("%s byte %0d", name, i), exp_bytes[i], rx_bytes[i]);
	endtask

	// Expects the header and then the payload in FIFO order
	task automatic take_stream(input string name, input logic wide, input logic [31:0] seq);
		int i;
		exp_bytes[0] = 8'hEF;
		exp_bytes[1] = 8'hFE;
		exp_bytes[2] = 8'h01;
		exp_bytes[3] = wide ? 8'h04 : 8'h06;
		{exp_bytes[4], exp_bytes[5], exp_bytes[6], exp_bytes[7]} = seq;
		for (i = 8; i < 1032; i++)
			exp_bytes[i] = wide ? sp_exp.pop_front() : iq_exp.pop_front();
		receive_frame(name, 11'd1032);
		compare_frame(name, 1032);
	endtask

	task automatic take_disc(input string name);
		logic [7:0]  id;
		logic [63:0] emu_name;
		int          i;
		id       = station.hermes_lite ? 8'h06 : 8'h01;
		emu_name = "HERMESLT";
		exp_bytes[0] = 8'hEF;
		exp_bytes[1] = 8'hFE;
		exp_bytes[2] = run ? 8'h03 : 8'h02;
		for (i = 0; i < 6; i++)
			exp_bytes[3 + i] = station.mac[47 - 8 * i -: 8]; // MSB first
		exp_bytes[9]  = station.serial_no;
		exp_bytes[10] = id;
		for (i = 0; i < 8; i++)
			exp_bytes[11 + i] = emu_name[63 - 8 * i -: 8];
		exp_bytes[19] = station.assign_nr;
		for (i = 20; i < 60; i++)
			exp_bytes[i] = id;
		receive_frame(name, 11'd60);
		compare_frame(name, 60);
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------
	task automatic discovery_replies();
		int i;
		station.mac       = 48'h00_1C_C0_A2_13_5E;
		station.serial_no = 8'h4A;
		station.assign_nr = 8'h02;
		discovery         = 1'b1;
		expect_no_request("discovery without ip", 20);
		ip_valid = 1'b1;
		for (i = 0; i < 4; i++) begin // Both run and hermes_lite values
			run                 = i[0];
			station.hermes_lite = i[1];
			discovery           = 1'b1;
			wait_request();
			discovery = 1'b0;
			take_disc($sformatf("discovery %0d", i));
		end
	endtask

	task automatic iq_streaming();
		run = 1'b1;
		fill_fifo(1'b0, 2048);
		take_stream("iq frame 0", 1'b0, 32'd0);
		take_stream("iq frame 1", 1'b0, 32'd1);
		@(negedge tx_clock); // Last pop has reached the model
		check_flag("iq underrun", 1'b0, underrun);
		check_flag("iq fifo drained", 1'b1, iq_q.size() == 0);
	endtask

	task automatic wide_streaming();
		wide_spectrum = 1'b1;
		fill_fifo(1'b1, 1024);
		take_stream("wide frame 0", 1'b1, 32'd0);
		fill_fifo(1'b0, 1024);
		take_stream("iq between wide", 1'b0, 32'd2); // Own counter
		fill_fifo(1'b1, 1024);
		take_stream("wide frame 1", 1'b1, 32'd1);
	endtask

	task automatic arbitration_order();
		fill_fifo(1'b0, 1024);
		fill_fifo(1'b1, 1024);
		discovery = 1'b1; // All three pending together
		wait_request();
		discovery = 1'b0;
		take_disc("arbitration discovery");
		take_stream("arbitration iq", 1'b0, 32'd3);
		take_stream("arbitration wide", 1'b1, 32'd2);
		tx_reset = 1'b1;
		fill_fifo(1'b0, 1024);
		expect_no_request("iq with tx_reset", 20);
		tx_reset = 1'b0;
		run      = 1'b0;
		expect_no_request("iq with run low", 20);
		run = 1'b1;
		take_stream("iq after block", 1'b0, 32'd0);
	endtask

	task automatic sequence_restart();
		run = 1'b0;
		repeat (4) @(negedge tx_clock);
		run = 1'b1;
		fill_fifo(1'b0, 1024);
		fill_fifo(1'b1, 1024);
		take_stream("iq after restart", 1'b0, 32'd0);
		take_stream("wide after restart", 1'b1, 32'd0);
	endtask

	task automatic back_pressure();
		backpressure = 1'b1;
		fill_fifo(1'b0, 1024);
		take_stream("iq back-pressure", 1'b0, 32'd1);
		fill_fifo(1'b1, 1024);
		take_stream("wide back-pressure", 1'b1, 32'd1);
		backpressure = 1'b0;
		@(negedge tx_clock);
		check_flag("final underrun", 1'b0, underrun);
		check_flag("fifos drained", 1'b1, iq_q.size() == 0 && sp_q.size() == 0);
	endtask

`endif

/* tb/tb_tx_send.sv */
`timescale 1ns/100ps
`default_nettype none

`include "metis_consts.svh"

module tb_tx_send;

	localparam int N_TESTS    = 6;
	localparam int TIMEOUT_NS = N_TESTS * 1100 * 4 * 10; // Bytes times worst-case cycles
	localparam int PAY_LEN    = `METIS_DATA_LEN - `METIS_HDR_LEN;

	logic                   tx_clock = 1'b0;
	logic                   rst;
	logic                   run;
	logic                   wide_spectrum;
	logic                   ip_valid;
	logic                   discovery;
	logic                   tx_reset;
	metis_pkg::station_id_s station;
	metis_pkg::fifo_rd_s    iq_fifo;
	metis_pkg::fifo_rd_s    sp_fifo;
	logic                   have_sp_data;
	logic                   iq_fifo_rdreq;
	logic                   sp_fifo_rdreq;
	metis_pkg::udp_req_s    udp_req;
	logic [7:0]             udp_tx_data;
	logic                   udp_tx_enable;
	logic                   udp_tx_active;
	logic                   underrun;

	integer     seed = 32'h6531;
	int         errors = 0;
	logic [7:0] iq_q[$];        // FIFO model contents
	logic [7:0] sp_q[$];
	logic [7:0] iq_exp[$];      // Bytes still owed to I/Q payloads
	logic [7:0] sp_exp[$];
	logic       iq_pop = 1'b0;
	logic       sp_pop = 1'b0;
	logic       backpressure = 1'b0; // Random active-low cycles
	logic [7:0] rx_bytes [`METIS_DATA_LEN];
	logic [7:0] exp_bytes [`METIS_DATA_LEN];

	`include "tb_tx_send_tasks.svh"

	always #5 tx_clock = ~tx_clock;

	tx_send tx_send_i (
		.tx_clock      (tx_clock),
		.rst           (rst),
		.run           (run),
		.wide_spectrum (wide_spectrum),
		.ip_valid      (ip_valid),
		.discovery     (discovery),
		.tx_reset      (tx_reset),
		.station       (station),
		.iq_fifo       (iq_fifo),
		.iq_fifo_rdreq (iq_fifo_rdreq),
		.sp_fifo       (sp_fifo),
		.have_sp_data  (have_sp_data),
		.sp_fifo_rdreq (sp_fifo_rdreq),
		.udp_req       (udp_req),
		.udp_tx_data   (udp_tx_data),
		.udp_tx_enable (udp_tx_enable),
		.udp_tx_active (udp_tx_active),
		.underrun      (underrun)
	);

	// ------------------------------------------------------------------
	// Show-ahead FIFO models
	// ------------------------------------------------------------------
	function automatic void refresh_fifos();
		iq_fifo.data = (iq_q.size() > 0) ? iq_q[0] : 8'h00;
		iq_fifo.used = (iq_q.size() > 2047) ? 11'd2047 : 11'(iq_q.size()); // Saturates
		sp_fifo.data = (sp_q.size() > 0) ? sp_q[0] : 8'h00;
		sp_fifo.used = (sp_q.size() > 2047) ? 11'd2047 : 11'(sp_q.size());
		have_sp_data = sp_q.size() >= PAY_LEN; // One full spectrum payload
	endfunction

	task automatic fill_fifo(input logic wide, input int n);
		logic [7:0] b;
		int         i;
		for (i = 0; i < n; i++) begin
			b = $random(seed);
			if (wide) begin
				sp_q.push_back(b);
				sp_exp.push_back(b);
			end else begin
				iq_q.push_back(b);
				iq_exp.push_back(b);
			end
		end
		refresh_fifos();
	endtask

	// Read requests seen at the edge, applied on the next falling edge
	always @(posedge tx_clock) begin
		iq_pop <= iq_fifo_rdreq;
		sp_pop <= sp_fifo_rdreq;
		if ((iq_fifo_rdreq || sp_fifo_rdreq) && !udp_tx_active) begin
			$display("FIFO read while the sender held active low at %0t", $time);
			errors++;
		end
	end

	always @(negedge tx_clock) begin
		if (iq_pop && iq_q.size() > 0)
			void'(iq_q.pop_front());
		if (sp_pop && sp_q.size() > 0)
			void'(sp_q.pop_front());
		refresh_fifos();
	end

	// ------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// Test sequence
	initial begin
		rst           = 1'b1;
		run           = 1'b0;
		wide_spectrum = 1'b0;
		ip_valid      = 1'b0;
		discovery     = 1'b0;
		tx_reset      = 1'b0;
		station       = '0;
		udp_tx_enable = 1'b0;
		udp_tx_active = 1'b0;
		refresh_fifos();
		repeat (16) @(negedge tx_clock);
		check_req("reset", '0, udp_req);
		check_byte("reset data", 8'h00, udp_tx_data);
		check_flag("reset iq rdreq", 1'b0, iq_fifo_rdreq);
		check_flag("reset sp rdreq", 1'b0, sp_fifo_rdreq);
		rst = 1'b0;
		discovery_replies();
		iq_streaming();
		wide_streaming();
		arbitration_order();
		sequence_restart();
		back_pressure();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
+incdir+tb
logic/metis_pkg.sv
logic/tx_frame_ctrl.sv
logic/frame_header_gen.sv
logic/payload_reader.sv
logic/discovery_reply_gen.sv
logic/tx_send.sv
tb/tb_tx_send.sv

/* Bender.yml */
package:
  name: metis_tx_send

export_include_dirs:
  - logic

sources:
  - logic/metis_pkg.sv
  - logic/tx_frame_ctrl.sv
  - logic/frame_header_gen.sv
  - logic/payload_reader.sv
  - logic/discovery_reply_gen.sv
  - logic/tx_send.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_tx_send.sv
